//--- src/lfps_timing_pkg.sv
// lfps timing constants
// scaled burst, repeat and window lengths

package lfps_timing_pkg;

	// counter word for every length and gap
	localparam int cnt_w = 10;

	// patterns told apart at burst end
	localparam int num_patterns = 3;
	// send request kinds, poll first
	localparam int num_sends = 5;

	////////////////////////////////////////////////////////////////////
	// receive windows, in slow_clk cycles
	////////////////////////////////////////////////////////////////////
	localparam int poll_len_min = 8;
	localparam int poll_len_max = 14;
	localparam int poll_gap_min = 40;
	localparam int poll_gap_max = 80;

	localparam int ping_len_min = 2;
	localparam int ping_len_max = 6;
	localparam int ping_gap_min = 100;
	localparam int ping_gap_max = 140;

	localparam int reset_len_min = 100;
	localparam int reset_len_max = 400;
	// burst still running past this is a warm reset
	localparam int reset_delay = 60;

	// in-burst exit thresholds
	localparam int u1_exit_min = 20;
	localparam int u2lb_exit_min = 30;
	localparam int u3_exit_min = 40;

	////////////////////////////////////////////////////////////////////
	// send tables, order poll, ping, u1, u2lb, u3
	////////////////////////////////////////////////////////////////////
	localparam logic [cnt_w-1:0] send_len [num_sends] = '{10, 4, 25, 35, 45};
	localparam logic [cnt_w-1:0] send_period [num_sends] = '{60, 120, 25, 35, 45};

	// matcher tables, order follows lfps_pattern_e
	localparam int len_min_tab [num_patterns] = '{poll_len_min, ping_len_min, reset_len_min};
	localparam int len_max_tab [num_patterns] = '{poll_len_max, ping_len_max, reset_len_max};
	localparam int gap_min_tab [num_patterns] = '{poll_gap_min, ping_gap_min, 0};
	localparam int gap_max_tab [num_patterns] = '{poll_gap_max, ping_gap_max, 0};
	localparam bit repeat_tab [num_patterns] = '{1'b1, 1'b1, 1'b0};

endpackage

//--- src/lfps_types_pkg.sv
// lfps signal bundles
// line, request, burst and event types

package lfps_types_pkg;

	// receiver side of the phy
	typedef struct packed {
		logic elecidle;
		logic valid;
	} lfps_rx_line_t;

	// transmitter side of the phy
	typedef struct packed {
		logic elecidle;
		logic detrx_lpbk;
	} lfps_tx_line_t;

	// level requests, highest priority first
	typedef struct packed {
		logic poll;
		logic ping;
		logic u1;
		logic u2lb;
		logic u3;
	} lfps_send_req_t;

	// burst record from the timer
	typedef struct packed {
		logic done;
		logic in_burst;
		logic [lfps_timing_pkg::cnt_w-1:0] length;
		logic [lfps_timing_pkg::cnt_w-1:0] gap;
		logic line_idle;
	} lfps_burst_t;

	// receive event flags, one cycle each
	typedef struct packed {
		logic active;
		logic poll_u1;
		logic ping;
		logic reset;
		logic u2lb;
		logic u3;
	} lfps_recv_evt_t;

	// index into the matcher hit vector
	typedef enum logic [1:0] {
		pat_poll,
		pat_ping,
		pat_reset
	} lfps_pattern_e;

	// P0 code of the phy power state
	localparam logic [1:0] power_p0 = 2'd0;

endpackage

//--- src/lfps_burst_timer.sv
// lfps burst timer
`timescale 1ns/1ps

module lfps_burst_timer #(
	parameter int sync_stages = 2,
	parameter int cnt_w = lfps_timing_pkg::cnt_w
) (
	input  logic slow_clk,
	input  logic lfps_send_reset_local,
	input  lfps_types_pkg::lfps_rx_line_t rx_line,
	output lfps_types_pkg::lfps_burst_t burst
);

	import lfps_types_pkg::*;

	// line value the synchronizer settles to out of reset
	localparam lfps_rx_line_t rx_idle = '{elecidle: 1'b1, valid: 1'b0};

	lfps_rx_line_t sync_q [sync_stages];
	lfps_rx_line_t line_s;

	logic in_burst;
	logic done_q;
	logic burst_start;
	logic burst_end;
	logic [cnt_w-1:0] len_cnt;
	logic [cnt_w-1:0] gap_cnt;
	logic [cnt_w-1:0] gap_last;

	// last stage is the only one the logic looks at
	assign line_s = sync_q[sync_stages-1];

	// burst needs both idle and valid low
	assign burst_start = !in_burst && !line_s.elecidle && !line_s.valid;
	// end is the rise of synchronized idle
	assign burst_end = in_burst && line_s.elecidle;

	//////////////////////////////////////////////////////////////////////
	// synchronizers
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge slow_clk) begin
		if (lfps_send_reset_local) begin
			for (int i = 0; i < sync_stages; i++) begin
				sync_q[i] <= rx_idle;
			end
		end else begin
			sync_q[0] <= rx_line;
			for (int i = 1; i < sync_stages; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// burst state, length and gap counters
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge slow_clk) begin
		if (lfps_send_reset_local) begin
			in_burst <= 1'b0;
			done_q <= 1'b0;
			len_cnt <= '0;
			gap_cnt <= '0;
			gap_last <= '0;
		end else begin
			done_q <= burst_end;
			// gap counter runs freely, sticks at the top
			if (gap_cnt != '1)
				gap_cnt <= gap_cnt + 1'b1;
			if (burst_start) begin
				in_burst <= 1'b1;
				len_cnt <= cnt_w'(1);
			end else if (burst_end) begin
				// end to end spacing, restart for the next burst
				in_burst <= 1'b0;
				gap_last <= gap_cnt;
				gap_cnt <= cnt_w'(1);
			end else if (in_burst && len_cnt != '1) begin
				len_cnt <= len_cnt + 1'b1;
			end
		end
	end

	// length and gap hold after done until the next burst
	always_comb begin
		burst.done = done_q;
		burst.in_burst = in_burst;
		burst.length = len_cnt;
		burst.gap = gap_last;
		burst.line_idle = line_s.elecidle;
	end

endmodule

//--- src/lfps_window_match.sv
// lfps burst pattern matcher
`timescale 1ns/1ps

module lfps_window_match #(
	parameter int cnt_w = lfps_timing_pkg::cnt_w,
	parameter int len_min = 0,
	parameter int len_max = 1,
	parameter int gap_min = 0,
	parameter int gap_max = 1,
	parameter bit need_repeat = 1'b0
) (
	input  logic slow_clk,
	input  logic lfps_send_reset_local,
	input  lfps_types_pkg::lfps_burst_t burst,
	output logic hit
);

	// window bounds in counter width
	localparam logic [cnt_w-1:0] len_lo = cnt_w'(len_min);
	localparam logic [cnt_w-1:0] len_hi = cnt_w'(len_max);
	localparam logic [cnt_w-1:0] gap_lo = cnt_w'(gap_min);
	localparam logic [cnt_w-1:0] gap_hi = cnt_w'(gap_max);

	logic seen_q;
	logic len_ok;
	logic gap_ok;

	// half open windows, max excluded
	assign len_ok = (burst.length >= len_lo) && (burst.length < len_hi);
	assign gap_ok = (burst.gap >= gap_lo) && (burst.gap < gap_hi);

	//////////////////////////////////////////////////////////////////////
	// classify at each burst end
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge slow_clk) begin
		if (lfps_send_reset_local) begin
			seen_q <= 1'b0;
			hit <= 1'b0;
		end else begin
			hit <= 1'b0;
			if (burst.done) begin
				if (len_ok) begin
					seen_q <= 1'b1;
					// repeated patterns need a matching burst before this one
					if (need_repeat)
						hit <= seen_q && gap_ok;
					else
						hit <= 1'b1;
				end else begin
					// any foreign burst breaks the pair
					seen_q <= 1'b0;
				end
			end
		end
	end

endmodule

//--- src/lfps_event_merge.sv
// lfps receive event merge
`timescale 1ns/1ps

module lfps_event_merge #(
	parameter int cnt_w = lfps_timing_pkg::cnt_w
) (
	input  logic slow_clk,
	input  logic lfps_send_reset_local,
	input  lfps_types_pkg::lfps_burst_t burst,
	input  logic [lfps_timing_pkg::num_patterns-1:0] hits,
	output lfps_types_pkg::lfps_recv_evt_t recv_evt,
	output logic warm_hold
);

	import lfps_types_pkg::*;
	import lfps_timing_pkg::*;

	localparam logic [cnt_w-1:0] u1_len = cnt_w'(u1_exit_min);
	localparam logic [cnt_w-1:0] u2lb_len = cnt_w'(u2lb_exit_min);
	localparam logic [cnt_w-1:0] u3_len = cnt_w'(u3_exit_min);
	localparam logic [cnt_w-1:0] hold_len = cnt_w'(reset_delay);

	logic u1_thr;
	logic u2lb_thr;
	logic u3_thr;
	lfps_recv_evt_t evt_d;

	// length passes each value once while counting up
	assign u1_thr = burst.in_burst && (burst.length == u1_len);
	assign u2lb_thr = burst.in_burst && (burst.length == u2lb_len);
	assign u3_thr = burst.in_burst && (burst.length == u3_len);

	always_comb begin
		evt_d.poll_u1 = hits[pat_poll] | u1_thr;
		evt_d.ping = hits[pat_ping];
		evt_d.reset = hits[pat_reset];
		evt_d.u2lb = u2lb_thr;
		evt_d.u3 = u3_thr;
		// active marks any flag in this cycle
		evt_d.active = evt_d.poll_u1 | evt_d.ping | evt_d.reset | evt_d.u2lb | evt_d.u3;
	end

	//////////////////////////////////////////////////////////////////////
	// registered events and warm reset hold
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge slow_clk) begin
		if (lfps_send_reset_local) begin
			recv_evt <= '0;
			warm_hold <= 1'b0;
		end else begin
			recv_evt <= evt_d;
			// hold from past the reset delay until the burst closes
			if (burst.done)
				warm_hold <= 1'b0;
			else if (burst.in_burst && burst.length > hold_len)
				warm_hold <= 1'b1;
		end
	end

endmodule

//--- src/lfps_tx_sequencer.sv
// lfps send sequencer
`timescale 1ns/1ps

module lfps_tx_sequencer #(
	parameter int cnt_w = lfps_timing_pkg::cnt_w
) (
	input  logic slow_clk,
	input  logic lfps_send_reset_local,
	input  lfps_types_pkg::lfps_send_req_t send_req,
	input  logic training,
	input  logic [1:0] power_state,
	input  logic warm_hold,
	input  lfps_types_pkg::lfps_burst_t burst,
	output lfps_types_pkg::lfps_tx_line_t tx_line,
	output logic send_ack
);

	import lfps_types_pkg::*;
	import lfps_timing_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_send,
		st_gap,
		st_hold
	} seq_state_e;

	localparam lfps_tx_line_t tx_idle = '{elecidle: 1'b1, detrx_lpbk: 1'b0};

	seq_state_e state;
	lfps_tx_line_t tx_on;
	logic req_any;
	logic [2:0] req_idx;
	logic [cnt_w-1:0] len_cnt;
	logic [cnt_w-1:0] per_cnt;

	// P0 signals lfps through detrx_lpbk, lower states by dropping idle
	always_comb begin
		if (power_state == power_p0)
			tx_on = '{elecidle: 1'b1, detrx_lpbk: 1'b1};
		else
			tx_on = '{elecidle: 1'b0, detrx_lpbk: 1'b0};
	end

	// fixed priority, index follows the send tables
	always_comb begin
		req_any = 1'b1;
		if (send_req.poll)
			req_idx = 3'd0;
		else if (send_req.ping)
			req_idx = 3'd1;
		else if (send_req.u1)
			req_idx = 3'd2;
		else if (send_req.u2lb)
			req_idx = 3'd3;
		else if (send_req.u3)
			req_idx = 3'd4;
		else begin
			req_any = 1'b0;
			req_idx = 3'd0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// send fsm
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge slow_clk) begin
		if (lfps_send_reset_local) begin
			state <= st_idle;
			len_cnt <= '0;
			per_cnt <= '0;
			tx_line <= tx_idle;
			send_ack <= 1'b0;
		end else begin
			tx_line <= tx_idle;
			send_ack <= 1'b0;
			case (state)
				st_idle: begin
					// requests only sampled here, nothing queued
					if (req_any && !training) begin
						len_cnt <= cnt_w'(send_len[req_idx]);
						per_cnt <= cnt_w'(send_period[req_idx]);
						tx_line <= tx_on;
						state <= st_send;
					end
				end
				st_send: begin
					len_cnt <= len_cnt - 1'b1;
					per_cnt <= per_cnt - 1'b1;
					if (len_cnt == cnt_w'(1)) begin
						// burst over, period may end with it
						if (per_cnt == cnt_w'(1)) begin
							send_ack <= 1'b1;
							state <= st_idle;
						end else begin
							state <= st_gap;
						end
					end else begin
						tx_line <= tx_on;
					end
				end
				st_gap: begin
					per_cnt <= per_cnt - 1'b1;
					if (per_cnt == cnt_w'(1)) begin
						send_ack <= 1'b1;
						state <= st_idle;
					end
				end
				default: begin
					// warm reset reply, ends when partner goes idle
					if (burst.line_idle)
						state <= st_idle;
					else
						tx_line <= tx_on;
				end
			endcase
			// warm reset wins over training and any send in flight
			if (warm_hold && !burst.line_idle) begin
				state <= st_hold;
				tx_line <= tx_on;
			end
		end
	end

endmodule

//--- src/lfps_engine.sv
// lfps engine top
`timescale 1ns/1ps

module lfps_engine #(
	parameter int sync_stages = 2,
	parameter int cnt_w = lfps_timing_pkg::cnt_w
) (
	input  logic slow_clk,
	input  logic lfps_send_reset_local,
	input  lfps_types_pkg::lfps_rx_line_t rx_line,
	input  logic [1:0] power_state,
	input  lfps_types_pkg::lfps_send_req_t send_req,
	input  logic training,
	output lfps_types_pkg::lfps_recv_evt_t recv_evt,
	output lfps_types_pkg::lfps_tx_line_t tx_line,
	output logic send_ack
);

	import lfps_types_pkg::*;
	import lfps_timing_pkg::*;

	lfps_burst_t burst;
	// one bit per lfps_pattern_e entry
	logic [num_patterns-1:0] hits;
	logic warm_hold;

	//////////////////////////////////////////////////////////////////////
	// receive path
	//////////////////////////////////////////////////////////////////////
	lfps_burst_timer #(
		.sync_stages(sync_stages),
		.cnt_w(cnt_w)
	) u_timer (
		.slow_clk(slow_clk),
		.lfps_send_reset_local(lfps_send_reset_local),
		.rx_line(rx_line),
		.burst(burst)
	);

	for (genvar i = 0; i < num_patterns; i++) begin : g_match
		lfps_window_match #(
			.cnt_w(cnt_w),
			.len_min(len_min_tab[i]),
			.len_max(len_max_tab[i]),
			.gap_min(gap_min_tab[i]),
			.gap_max(gap_max_tab[i]),
			.need_repeat(repeat_tab[i])
		) u_match (
			.slow_clk(slow_clk),
			.lfps_send_reset_local(lfps_send_reset_local),
			.burst(burst),
			.hit(hits[i])
		);
	end

	lfps_event_merge #(
		.cnt_w(cnt_w)
	) u_merge (
		.slow_clk(slow_clk),
		.lfps_send_reset_local(lfps_send_reset_local),
		.burst(burst),
		.hits(hits),
		.recv_evt(recv_evt),
		.warm_hold(warm_hold)
	);

	//////////////////////////////////////////////////////////////////////
	// send path
	//////////////////////////////////////////////////////////////////////
	lfps_tx_sequencer #(
		.cnt_w(cnt_w)
	) u_seq (
		.slow_clk(slow_clk),
		.lfps_send_reset_local(lfps_send_reset_local),
		.send_req(send_req),
		.training(training),
		.power_state(power_state),
		.warm_hold(warm_hold),
		.burst(burst),
		.tx_line(tx_line),
		.send_ack(send_ack)
	);

endmodule

//--- testbench/lfps_engine_tb.sv
// lfps engine testbench
`timescale 1ns/1ps

module lfps_engine_tb;

	import lfps_types_pkg::*;

	// warm reset reply window, counted from burst start
	localparam int hold_after = 60;
	localparam int hold_slack = 10;
	// wait limits in cycles
	localparam int send_timeout = 400;
	localparam int train_wait = 150;
	localparam logic [1:0] p0_code = 2'd0;

	localparam lfps_rx_line_t rx_idle = '{elecidle: 1'b1, valid: 1'b0};
	localparam lfps_rx_line_t rx_burst = '{elecidle: 1'b0, valid: 1'b0};
	// transmitter quiet, idle high and no loopback
	localparam lfps_tx_line_t tx_idle = '{elecidle: 1'b1, detrx_lpbk: 1'b0};

	logic slow_clk;
	logic lfps_send_reset_local;
	lfps_rx_line_t rx_line;
	logic [1:0] power_state;
	lfps_send_req_t send_req;
	logic training;
	lfps_recv_evt_t recv_evt;
	lfps_tx_line_t tx_line;
	logic send_ack;

	// per step observations
	int n;
	int evt_cnt [6];
	int on_cnt;
	int first_on;
	int last_on;
	int ack_cnt;
	int ack_at;

	// golden file reading
	int fd;
	int rnd;
	int fields;
	int steps;
	reg [8*128-1:0] text_line;
	reg [15:0] tag;
	int f_len;
	int f_idle;
	int f_pwr;
	int f_trn;
	int f_per;
	logic [7:0] f_code;
	logic [7:0] f_req;
	logic [7:0] f_late;

	lfps_engine dut (
		.slow_clk(slow_clk),
		.lfps_send_reset_local(lfps_send_reset_local),
		.rx_line(rx_line),
		.power_state(power_state),
		.send_req(send_req),
		.training(training),
		.recv_evt(recv_evt),
		.tx_line(tx_line),
		.send_ack(send_ack)
	);

	// 20 ns period
	always #10 slow_clk = ~slow_clk;

	task automatic stop_run(input string msg);
		$display(">>> FAIL");
		$display("%s", msg);
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected != actual)
			stop_run($sformatf("FAIL t=%0t %s expected %0d got %0d",
				$time, name, expected, actual));
	endtask

	function automatic string flag_name(input int i);
		case (i)
			0: return "recv_evt.u3";
			1: return "recv_evt.u2lb";
			2: return "recv_evt.reset";
			3: return "recv_evt.ping";
			default: return "recv_evt.poll_u1";
		endcase
	endfunction

	task automatic clear_counts();
		n = 0;
		on_cnt = 0;
		first_on = -1;
		last_on = -1;
		ack_cnt = 0;
		ack_at = -1;
		for (int i = 0; i < 6; i++)
			evt_cnt[i] = 0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// one cycle, sampled on the falling edge
	//////////////////////////////////////////////////////////////////////
	task automatic tick();
		@(negedge slow_clk);
		n++;
		// exit thresholds grow with length, so u1 comes first
		if (recv_evt.u2lb && evt_cnt[4] == 0)
			stop_run("u2lb exit event came before the u1 exit event");
		if (recv_evt.u3 && evt_cnt[1] == 0)
			stop_run("u3 exit event came before the u2lb exit event");
		for (int i = 0; i < 6; i++) begin
			if (recv_evt[i])
				evt_cnt[i]++;
		end
		if (tx_line != tx_idle) begin
			if (on_cnt == 0)
				first_on = n;
			last_on = n;
			on_cnt++;
			// P0 uses detrx_lpbk, other states drop elecidle
			check_value("tx_line", (power_state == p0_code) ? 3 : 0, tx_line);
		end
		if (send_ack) begin
			if (ack_cnt == 0)
				ack_at = n;
			ack_cnt++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// receive step, one burst then idle
	//////////////////////////////////////////////////////////////////////
	task automatic run_burst(input int len, input int idle, input logic [7:0] code);
		int gap_cycles;
		clear_counts();
		rx_line = rx_burst;
		repeat (len) tick();
		rx_line = rx_idle;
		// zero closes a group, spacing then far outside every window
		gap_cycles = (idle != 0) ? idle : 200 + $urandom % 50;
		repeat (gap_cycles) tick();
		for (int i = 0; i < 5; i++)
			check_value(flag_name(i), code[i], evt_cnt[i]);
		check_value("recv_evt.active", code[5], evt_cnt[5] != 0);
		check_value("recv_evt.active pulses", $countones(code[4:0]), evt_cnt[5]);
		if (len > hold_after) begin
			check_value($sformatf("warm reply start %0d in window", first_on), 1,
				first_on >= hold_after && first_on <= hold_after + hold_slack);
			check_value($sformatf("warm reply end %0d in window", last_on), 1,
				last_on >= len && last_on <= len + hold_slack);
			check_value("warm reply active cycles", last_on - first_on + 1, on_cnt);
		end else begin
			check_value("tx active cycles", 0, on_cnt);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// send step, request held until the ack
	//////////////////////////////////////////////////////////////////////
	task automatic run_send(input logic [7:0] req, input logic [7:0] late, input int pwr,
			input int trn, input int len, input int per);
		clear_counts();
		power_state = pwr[1:0];
		training = trn[0];
		send_req = req[4:0];
		if (len == 0) begin
			// gated, nothing may start in the window
			repeat (train_wait) tick();
			check_value("tx active cycles", 0, on_cnt);
			check_value("send_ack pulses", 0, ack_cnt);
		end else begin
			while (ack_cnt == 0 && n < send_timeout) begin
				tick();
				// extra request lands on the first active cycle
				if (on_cnt == 1 && first_on == n)
					send_req = req[4:0] | late[4:0];
			end
			if (ack_cnt == 0)
				stop_run("timed out waiting for send_ack");
			check_value("tx active cycles", len, on_cnt);
			check_value("tx active span", last_on - first_on + 1, on_cnt);
			check_value("send_ack delay", per, ack_at - first_on);
		end
		send_req = '0;
		training = 1'b0;
		// quiet spell, no leftover request may start a send
		clear_counts();
		repeat (20 + $urandom % 20) tick();
		check_value("tx active cycles after step", 0, on_cnt);
		check_value("send_ack pulses after step", 0, ack_cnt);
	endtask

	initial begin
		slow_clk = 1'b0;
		rnd = $urandom(15);
		lfps_send_reset_local = 1'b1;
		rx_line = rx_idle;
		power_state = p0_code;
		send_req = '0;
		training = 1'b0;
		steps = 0;
		clear_counts();
		repeat (4) @(negedge slow_clk);
		lfps_send_reset_local = 1'b0;
		check_value("recv_evt", 0, recv_evt);
		check_value("send_ack", 0, send_ack);
		check_value("tx_line", tx_idle, tx_line);

		fd = $fopen("testbench/lfps_golden.txt", "r");
		if (fd == 0)
			stop_run("could not open testbench/lfps_golden.txt");
		while ($fgets(text_line, fd) != 0) begin
			fields = $sscanf(text_line, "%s", tag);
			if (fields == 1 && tag == "B") begin
				fields = $sscanf(text_line, "%s %d %d %h", tag, f_len, f_idle, f_code);
				if (fields != 4)
					stop_run("malformed burst line in golden file");
				run_burst(f_len, f_idle, f_code);
				steps++;
			end else if (fields == 1 && tag == "S") begin
				fields = $sscanf(text_line, "%s %h %h %d %d %d %d", tag, f_req, f_late,
					f_pwr, f_trn, f_len, f_per);
				if (fields != 7)
					stop_run("malformed send line in golden file");
				run_send(f_req, f_late, f_pwr, f_trn, f_len, f_per);
				steps++;
			end else if (fields == 1 && tag != "#") begin
				stop_run("unknown step kind in golden file");
			end
		end
		$fclose(fd);
		check_value("golden steps run", 1, steps > 0);
		$display(">>> PASS");
		$finish;
	end

endmodule

//--- testbench/lfps_golden.txt
# B burst_len idle_after(0 = random spacing) evt_code(hex: active poll_u1 ping reset u2lb u3)
# S req(hex: poll ping u1 u2lb u3) late_req power training active_cycles period
B 11 49 00
B 11 0 30
B 11 0 00
B 11 139 00
B 11 0 00
B 4 116 00
B 4 0 28
B 45 0 33
B 200 0 37
S 10 00 0 0 10 60
S 08 00 0 0 4 120
S 04 00 0 0 25 25
S 02 00 0 0 35 35
S 01 00 0 0 45 45
S 10 00 2 0 10 60
S 01 00 3 0 45 45
S 11 00 0 0 10 60
S 04 00 0 1 0 0
S 04 10 0 0 25 25

//--- sim.f
src/lfps_timing_pkg.sv
src/lfps_types_pkg.sv
src/lfps_burst_timer.sv
src/lfps_window_match.sv
src/lfps_event_merge.sv
src/lfps_tx_sequencer.sv
src/lfps_engine.sv
testbench/lfps_engine_tb.sv
